/* src/fetch_pkg.sv */
`default_nettype none

package fetch_pkg;

  // Line geometry of the instruction cache.
  localparam int offset_bits = 4;            // 16-byte lines.
  localparam int index_bits  = 1;
  localparam int line_count  = 2 ** index_bits;
  localparam int line_bits   = (2 ** offset_bits) * 8;
  localparam int tag_bits    = 32 - offset_bits - index_bits;

  // First fetch address out of reset.
  localparam logic [31:0] reset_pc = 32'h3000_0000;

  // Stages the misaligned-fetch flag travels before it reaches the pipeline.
  localparam int misalign_delay = 4;

  typedef logic [31:0] addr_t;
  typedef logic [tag_bits-1:0] tag_t;
  typedef logic [index_bits-1:0] index_t;

endpackage

`default_nettype wire

/* src/bus_pkg.sv */
`default_nettype none

package bus_pkg;

  // One refill is a single incrementing read burst.
  localparam int beat_bits      = 32;
  localparam int beats_per_line = 4;
  localparam logic [7:0] burst_len = 8'(beats_per_line - 1);  // arlen encoding.

  // Read response codes.
  localparam logic [1:0] resp_okay = 2'b00;

  typedef logic [beat_bits-1:0] beat_t;
  typedef logic [1:0] resp_t;

endpackage

`default_nettype wire

/* src/icache_store.sv */
`timescale 1ns/100ps
`default_nettype none

module icache_store
  import fetch_pkg::*;
  import bus_pkg::*;
(
  input  logic  clock,
  input  logic  reset,
  input  addr_t lookup_addr,
  output logic  hit,
  output addr_t hit_word,
  input  logic  fill_tag_write,
  input  logic  fill_beat,
  input  beat_t fill_data,
  input  logic  clear_cache
);

  logic [line_count-1:0] valid;
  tag_t                  tags  [line_count];
  logic [line_bits-1:0]  lines [line_count];

  index_t               index;
  tag_t                 addr_tag;
  logic [1:0]           word_sel;
  logic [line_bits-1:0] line;

  assign index    = lookup_addr[offset_bits +: index_bits];
  assign addr_tag = lookup_addr[31 -: tag_bits];
  assign word_sel = lookup_addr[offset_bits-1:2];
  assign line     = lines[index];

  assign hit      = valid[index] && (tags[index] == addr_tag);
  assign hit_word = line[word_sel * beat_bits +: beat_bits];

  // Valid bits. A tag write after a clear in the same cycle still wins.
  always_ff @(posedge clock) begin
    if (reset) begin
      valid <= '0;
    end else begin
      if (clear_cache) begin
        valid <= '0;
      end
      if (fill_tag_write) begin
        valid[index] <= 1'b1;
      end
    end
  end

  always_ff @(posedge clock) begin
    if (fill_tag_write) begin
      tags[index] <= addr_tag;
    end
  end

  // Beats enter at the top, so after four of them beat 0 sits in the low word.
  always_ff @(posedge clock) begin
    if (fill_beat) begin
      lines[index] <= {fill_data, lines[index][line_bits-1:beat_bits]};
    end
  end

  // A clear in the middle of a fill would leave a half-written line marked invalid
  // while the refill engine still believes it owns it.
  assert property (@(posedge clock) disable iff (reset)
    fill_beat |-> !clear_cache);

endmodule

`default_nettype wire

/* src/line_refill.sv */
`timescale 1ns/100ps
`default_nettype none

module line_refill
  import fetch_pkg::*;
  import bus_pkg::*;
(
  input  logic       clock,
  input  logic       reset,
  input  logic       refill_start,
  input  addr_t      refill_addr,
  output logic       busy,
  output logic       fill_tag_write,
  output logic       fill_beat,
  output logic       refill_done,
  output beat_t      fill_data,
  output addr_t      araddr,
  output logic       arvalid,
  output logic [7:0] arlen,
  input  logic       arready,
  output logic       rready,
  input  beat_t      rdata,
  input  resp_t      rresp,
  input  logic       rvalid,
  input  logic       rlast
);

  typedef enum logic [1:0] {
    st_idle,
    st_addr,
    st_data
  } state_t;

  state_t state;
  logic [$clog2(beats_per_line)-1:0] beat_count;

  assign busy    = (state != st_idle);
  assign arvalid = (state == st_addr);   // Held until the slave takes it.
  assign rready  = (state == st_data);
  assign arlen   = burst_len;

  assign fill_tag_write = arvalid && arready;
  assign fill_beat      = rready && rvalid;
  assign fill_data      = rdata;
  assign refill_done    = fill_beat && rlast;

  always_ff @(posedge clock) begin
    if (reset) begin
      state      <= st_idle;
      beat_count <= '0;
    end else begin
      case (state)
        st_idle: begin
          if (refill_start) begin
            state      <= st_addr;
            beat_count <= '0;
          end
        end
        st_addr: begin
          if (arready) state <= st_data;
        end
        st_data: begin
          if (fill_beat) begin
            beat_count <= beat_count + 1'b1;
            if (rlast) state <= st_idle;
          end
        end
        default: state <= st_idle;
      endcase
    end
  end

  always_ff @(posedge clock) begin
    if (refill_start) araddr <= refill_addr;
  end

  // Error responses are not handled by the cache.
  assert property (@(posedge clock) disable iff (reset)
    fill_beat |-> rresp == resp_okay);

  assert property (@(posedge clock) disable iff (reset)
    fill_beat |-> rlast == (beat_count == 2'(beats_per_line - 1)));

  assert property (@(posedge clock) disable iff (reset)
    refill_start |-> !busy);

endmodule

`default_nettype wire

/* src/fetch_control.sv */
`timescale 1ns/100ps
`default_nettype none

module fetch_control
  import fetch_pkg::*;
(
  input  logic  clock,
  input  logic  reset,
  input  addr_t npc,
  input  logic  npc_valid,
  input  logic  idu_ready,
  input  logic  block,
  input  logic  clear_pipeline,
  output addr_t ifu_pc,
  output addr_t inst,
  output logic  inst_valid,
  output logic  inst_addr_misaligned,
  output addr_t lookup_addr,
  input  logic  hit,
  input  addr_t hit_word,
  input  logic  busy,
  input  logic  refill_done,
  output logic  refill_start,
  output addr_t refill_addr
);

  addr_t pc;
  logic  pipeline_empty;   // No word handed out since the last redirect.
  logic  refill_pending;
  logic [misalign_delay-1:0] misalign_pipe;

  logic advance;
  logic can_issue;
  logic start_ok;

  assign lookup_addr = pc;
  assign refill_addr = {pc[31:offset_bits], {offset_bits{1'b0}}};

  assign advance   = idu_ready && !block;
  assign can_issue = advance && !refill_pending && (misalign_pipe == '0);

  // Only fetch from memory for a pc the pipeline has confirmed.
  assign start_ok     = pipeline_empty || (npc_valid && (npc == pc));
  assign refill_start = !clear_pipeline && can_issue && !hit && start_ok;

  assign inst_addr_misaligned = misalign_pipe[misalign_delay-1];

  always_ff @(posedge clock) begin
    if (reset) begin
      pc             <= reset_pc;
      pipeline_empty <= 1'b1;
      refill_pending <= 1'b0;
      inst_valid     <= 1'b0;
      misalign_pipe  <= '0;
    end else begin
      if (refill_start) begin
        refill_pending <= 1'b1;
      end else if (refill_done) begin
        refill_pending <= 1'b0;   // Line is complete from the next cycle.
      end

      if (!block) begin
        misalign_pipe[misalign_delay-1:1] <= misalign_pipe[misalign_delay-2:0];
      end

      if (clear_pipeline) begin
        pc             <= npc;
        inst_valid     <= 1'b0;
        pipeline_empty <= 1'b1;
        if (npc[1:0] == 2'b00) begin
          misalign_pipe <= '0;
        end else begin
          misalign_pipe[0] <= 1'b1;   // Stays set until the next redirect.
        end
      end else if (can_issue) begin
        if (hit) begin
          inst_valid     <= 1'b1;
          pipeline_empty <= 1'b0;
          pc             <= pc + 32'd4;
        end else begin
          inst_valid <= 1'b0;
        end
      end
    end
  end

  // Presented word and its pc.
  always_ff @(posedge clock) begin
    if (clear_pipeline) begin
      if (npc[1:0] != 2'b00) ifu_pc <= npc;
    end else if (can_issue && hit) begin
      ifu_pc <= pc;
      inst   <= hit_word;
    end
  end

  assert property (@(posedge clock) disable iff (reset)
    inst_valid |-> ifu_pc[1:0] == 2'b00);

  // The controller's view of an open refill must match the engine's.
  assert property (@(posedge clock) disable iff (reset)
    refill_pending == busy);

endmodule

`default_nettype wire

/* src/ifu_top.sv */
`timescale 1ns/100ps
`default_nettype none

module ifu_top
  import fetch_pkg::*;
  import bus_pkg::*;
(
  input  logic       clock,
  input  logic       reset,
  input  addr_t      npc,
  input  logic       npc_valid,
  output addr_t      ifu_pc,
  output logic       inst_valid,
  output addr_t      inst,
  input  logic       idu_ready,
  input  logic       block,
  output logic       enable,
  output addr_t      araddr,
  output logic       arvalid,
  output logic [7:0] arlen,
  input  logic       arready,
  output logic       rready,
  input  beat_t      rdata,
  input  resp_t      rresp,
  input  logic       rvalid,
  input  logic       rlast,
  output logic       inst_addr_misaligned,
  input  logic       clear_cache,
  input  logic       clear_pipeline
);

  addr_t lookup_addr;
  logic  hit;
  addr_t hit_word;
  logic  refill_start;
  addr_t refill_addr;
  logic  busy;
  logic  fill_tag_write;
  logic  fill_beat;
  logic  refill_done;
  beat_t fill_data;

  assign enable = busy;   // High for the whole burst.

  icache_store u_store (
    .clock          (clock),
    .reset          (reset),
    .lookup_addr    (lookup_addr),
    .hit            (hit),
    .hit_word       (hit_word),
    .fill_tag_write (fill_tag_write),
    .fill_beat      (fill_beat),
    .fill_data      (fill_data),
    .clear_cache    (clear_cache)
  );

  line_refill u_refill (
    .clock          (clock),
    .reset          (reset),
    .refill_start   (refill_start),
    .refill_addr    (refill_addr),
    .busy           (busy),
    .fill_tag_write (fill_tag_write),
    .fill_beat      (fill_beat),
    .refill_done    (refill_done),
    .fill_data      (fill_data),
    .araddr         (araddr),
    .arvalid        (arvalid),
    .arlen          (arlen),
    .arready        (arready),
    .rready         (rready),
    .rdata          (rdata),
    .rresp          (rresp),
    .rvalid         (rvalid),
    .rlast          (rlast)
  );

  fetch_control u_control (
    .clock                (clock),
    .reset                (reset),
    .npc                  (npc),
    .npc_valid            (npc_valid),
    .idu_ready            (idu_ready),
    .block                (block),
    .clear_pipeline       (clear_pipeline),
    .ifu_pc               (ifu_pc),
    .inst                 (inst),
    .inst_valid           (inst_valid),
    .inst_addr_misaligned (inst_addr_misaligned),
    .lookup_addr          (lookup_addr),
    .hit                  (hit),
    .hit_word             (hit_word),
    .busy                 (busy),
    .refill_done          (refill_done),
    .refill_start         (refill_start),
    .refill_addr          (refill_addr)
  );

endmodule

`default_nettype wire

/* tb/rom_responder.sv */
`timescale 1ns/100ps
`default_nettype none

module rom_responder
  import fetch_pkg::*;
  import bus_pkg::*;
#(
  parameter logic [31:0] seed = 32'd46235
)
(
  input  logic       clock,
  input  logic       reset,
  input  addr_t      araddr,
  input  logic       arvalid,
  input  logic [7:0] arlen,
  output logic       arready,
  input  logic       rready,
  output beat_t      rdata,
  output resp_t      rresp,
  output logic       rvalid,
  output logic       rlast
);

  logic [31:0] rnd = seed;
  logic        in_burst = 1'b0;
  addr_t       base = '0;
  logic [1:0]  beat = 2'd0;
  logic [1:0]  last_beat = 2'd0;   // Beat index that carries rlast.
  logic [1:0]  ar_wait = 2'd0;   // Cycles before the address is taken.
  logic [1:0]  gap = 2'd0;       // Idle cycles before the next beat.
  logic        ar_ready_q = 1'b0;
  logic        r_valid_q = 1'b0;
  logic        r_last_q = 1'b0;
  beat_t       r_data_q = '0;

  function automatic logic [31:0] next_random(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  // ROM contents follow from the address alone.
  function automatic beat_t rom_word(input addr_t a);
    return (a ^ 32'h5A5A_0000) + {a[24:0], a[31:25]};
  endfunction

  assign arready = ar_ready_q;
  assign rvalid  = r_valid_q;
  assign rlast   = r_last_q;
  assign rdata   = r_data_q;
  assign rresp   = resp_okay;

  always @(posedge clock) begin
    rnd = next_random(rnd);
    if (reset) begin
      ar_ready_q <= 1'b0;
      r_valid_q  <= 1'b0;
      r_last_q   <= 1'b0;
      in_burst   <= 1'b0;
      ar_wait    <= 2'd0;
      gap        <= 2'd0;
      beat       <= 2'd0;
    end else if (!in_burst) begin
      if (arvalid && ar_ready_q) begin
        ar_ready_q <= 1'b0;
        in_burst   <= 1'b1;
        base       <= araddr;
        last_beat  <= arlen[1:0];
        beat       <= 2'd0;
        gap        <= rnd[1:0];
      end else if (arvalid) begin
        if (ar_wait == 2'd0) ar_ready_q <= 1'b1;
        else ar_wait <= ar_wait - 2'd1;
      end
    end else if (r_valid_q) begin
      if (rready) begin
        r_valid_q <= 1'b0;
        r_last_q  <= 1'b0;
        beat      <= beat + 2'd1;
        gap       <= rnd[1:0];
        if (r_last_q) begin
          in_burst <= 1'b0;
          ar_wait  <= rnd[3:2];
        end
      end
    end else if (gap != 2'd0) begin
      gap <= gap - 2'd1;
    end else begin
      r_valid_q <= 1'b1;
      r_data_q  <= rom_word(base + {28'd0, beat, 2'b00});
      r_last_q  <= (beat == last_beat);
    end
  end

endmodule

`default_nettype wire

/* tb/ifu_tb.sv */
`timescale 1ns/100ps
`default_nettype none

module ifu_tb
  import fetch_pkg::*;
  import bus_pkg::*;
;

  localparam int fetch_total = 96;
  localparam int cycle_limit = 40 * fetch_total + 200;

  logic clock = 1'b0;
  logic reset = 1'b1;
  addr_t npc = reset_pc;
  logic npc_valid = 1'b1;
  logic idu_ready = 1'b0;
  logic block = 1'b0;
  logic clear_cache = 1'b0;
  logic clear_pipeline = 1'b0;
  wire addr_t ifu_pc;
  wire addr_t inst;
  wire logic inst_valid;
  wire logic enable;
  wire addr_t araddr;
  wire logic arvalid;
  wire logic [7:0] arlen;
  wire logic arready;
  wire logic rready;
  wire beat_t rdata;
  wire resp_t rresp;
  wire logic rvalid;
  wire logic rlast;
  wire logic inst_addr_misaligned;

  // Requests from the main process to the input driver.
  logic req_redirect = 1'b0;
  logic req_clear = 1'b0;
  logic random_mode = 1'b0;
  addr_t redirect_target = '0;
  addr_t npc_next = reset_pc;
  logic [31:0] rnd_state = 32'd46235;

  addr_t expect_pc = reset_pc;   // Address of the next word to be taken.
  addr_t burst_addr[$];
  int burst_count = 0;
  int accepted = 0;
  int error_count = 0;
  int check_count = 0;
  int test_start_errors = 0;
  int cycle_count = 0;

  ifu_top u_dut (
    .clock(clock), .reset(reset), .npc(npc), .npc_valid(npc_valid),
    .ifu_pc(ifu_pc), .inst_valid(inst_valid), .inst(inst),
    .idu_ready(idu_ready), .block(block), .enable(enable),
    .araddr(araddr), .arvalid(arvalid), .arlen(arlen), .arready(arready),
    .rready(rready), .rdata(rdata), .rresp(rresp), .rvalid(rvalid), .rlast(rlast),
    .inst_addr_misaligned(inst_addr_misaligned),
    .clear_cache(clear_cache), .clear_pipeline(clear_pipeline)
  );

  rom_responder #(.seed(32'd46235)) u_rom (
    .clock(clock), .reset(reset), .araddr(araddr), .arvalid(arvalid), .arlen(arlen),
    .arready(arready), .rready(rready), .rdata(rdata), .rresp(rresp),
    .rvalid(rvalid), .rlast(rlast)
  );

  always #50 clock = ~clock;

  function automatic logic [31:0] xorshift(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  // Expected instruction word at a byte address.
  function automatic addr_t mem_word(input addr_t a);
    return (a ^ 32'h5A5A_0000) + {a[24:0], a[31:25]};
  endfunction

  task automatic check_addr(input string name, input addr_t got, input addr_t exp);
    check_count++;
    if (got !== exp) begin
      error_count++;
      $display("Error: %s got %h expected %h", name, got, exp);
    end
  endtask

  task automatic check_word(input string name, input addr_t got, input addr_t exp);
    check_count++;
    if (got !== exp) begin
      error_count++;
      $display("Error: %s got %h expected %h", name, got, exp);
    end
  endtask

  task automatic check_len(input string name, input logic [7:0] got, input logic [7:0] exp);
    check_count++;
    if (got !== exp) begin
      error_count++;
      $display("Error: %s got %h expected %h", name, got, exp);
    end
  endtask

  task automatic check_flag(input string name, input logic got, input logic exp);
    check_count++;
    if (got !== exp) begin
      error_count++;
      $display("Error: %s got %h expected %h", name, got, exp);
    end
  endtask

  always @(posedge clock) begin
    if (reset) begin
      idu_ready      <= 1'b0;
      block          <= 1'b0;
      clear_pipeline <= 1'b0;
      clear_cache    <= 1'b0;
      npc            <= reset_pc;
    end else begin
      clear_pipeline <= req_redirect;
      clear_cache    <= req_clear;
      npc            <= req_redirect ? redirect_target : npc_next;
      if (random_mode) begin
        rnd_state = xorshift(rnd_state);
        idu_ready <= rnd_state[0] | rnd_state[5];
        block     <= rnd_state[9] & rnd_state[12];
      end else begin
        idu_ready <= 1'b1;
        block     <= 1'b0;
      end
    end
  end

  always @(posedge clock) begin
    cycle_count <= cycle_count + 1;
    if (cycle_count >= cycle_limit) begin
      $display("Timeout: fetch stream stalled after %0d cycles", cycle_count);
      $display("Test failed");
      $finish;
    end
  end

  // One cycle, sampled at the falling edge where every signal is settled.
  task automatic step();
    @(negedge clock);
    if (arvalid && arready) begin
      burst_count++;
      burst_addr.push_back(araddr);
      check_addr("araddr", araddr, {expect_pc[31:4], 4'h0});   // Line of the waiting pc.
      check_len("arlen", arlen, 8'd3);   // Four beats.
    end
    if (clear_pipeline) begin
      expect_pc = npc;
    end else if (inst_valid && idu_ready && !block) begin
      check_addr("ifu_pc", ifu_pc, expect_pc);
      check_word("inst", inst, mem_word(expect_pc));
      expect_pc = expect_pc + 32'd4;
      accepted++;
    end
    npc_next = expect_pc;
  endtask

  task automatic wait_words(input int n);
    int target;
    target = accepted + n;
    while (accepted < target) step();
  endtask

  task automatic redirect(input addr_t target, input logic with_clear);
    req_redirect    = 1'b1;
    redirect_target = target;
    req_clear       = with_clear;
    step();
    req_redirect = 1'b0;
    req_clear    = 1'b0;
  endtask

  task automatic end_test(input string name);
    $display("%-26s %0d errors", name, error_count - test_start_errors);
    test_start_errors = error_count;
  endtask

  initial begin
    int b;
    int n;
    repeat (5) @(posedge clock);
    reset <= 1'b0;
    step();
    check_flag("arvalid", arvalid, 1'b0);
    check_flag("rready", rready, 1'b0);
    check_flag("inst_valid", inst_valid, 1'b0);
    check_flag("enable", enable, 1'b0);
    check_flag("inst_addr_misaligned", inst_addr_misaligned, 1'b0);

    wait_words(32);
    check_flag("eight bursts", burst_count == 8, 1'b1);
    end_test("sequential fetch");

    b = burst_count;
    redirect(32'h3000_0100, 1'b0);
    wait_words(8);
    check_flag("two bursts", burst_count == b + 2, 1'b1);
    check_addr("araddr", burst_addr[b], 32'h3000_0100);
    check_addr("araddr", burst_addr[b + 1], 32'h3000_0110);
    redirect(32'h3000_0100, 1'b0);
    wait_words(8);
    check_flag("second pass arvalid", burst_count != b + 2, 1'b0);
    end_test("loop over cached region");

    redirect(32'h3000_0110, 1'b0);   // Hits keep coming until the jump.
    wait_words(2);
    redirect(32'h3000_0200, 1'b0);
    step();
    check_flag("inst_valid", inst_valid, 1'b0);
    wait_words(6);
    end_test("aligned redirect");

    while (enable) step();
    b = burst_count;
    redirect(32'h3000_0200, 1'b1);   // Flush together with the jump back.
    wait_words(4);
    check_flag("refetch burst", burst_count == b + 1, 1'b1);
    check_addr("araddr", burst_addr[b], 32'h3000_0200);
    end_test("cache clear");

    redirect(32'h3000_0302, 1'b0);
    step();
    check_addr("ifu_pc", ifu_pc, 32'h3000_0302);
    n = 1;
    while (!inst_addr_misaligned && n < 10) begin
      step();
      n++;
    end
    check_flag("misaligned after four cycles", n == 4, 1'b1);
    repeat (10) begin
      step();
      check_flag("arvalid", arvalid, 1'b0);
      check_flag("inst_addr_misaligned", inst_addr_misaligned, 1'b1);
    end
    redirect(32'h3000_0400, 1'b0);
    step();
    check_flag("inst_addr_misaligned", inst_addr_misaligned, 1'b0);
    wait_words(4);
    end_test("misaligned redirect");

    redirect(reset_pc, 1'b0);
    random_mode = 1'b1;
    wait_words(32);
    random_mode = 1'b0;
    end_test("back-pressure");

    $display("checks %0d, errors %0d", check_count, error_count);
    if (error_count == 0) begin
      $display("Test completed successfully");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* ifu_top.f */
src/fetch_pkg.sv
src/bus_pkg.sv
src/icache_store.sv
src/line_refill.sv
src/fetch_control.sv
src/ifu_top.sv
tb/rom_responder.sv
tb/ifu_tb.sv

/* run_sim.sh */
#!/usr/bin/env bash
# Build and run the fetch unit testbench with Verilator.
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -f ifu_top.f --top-module ifu_tb \
  -Mdir obj_dir -o ifu_sim || exit 1
sim_out="$(./obj_dir/ifu_sim)"
echo "$sim_out"
echo "$sim_out" | grep -qx "Test completed successfully" && exit 0 || exit 1
